// ==== hdl/dcache_pkg.sv ====
/* shared cache metadata definitions: line index split into dirty RAM row and column,
   the line index type and the miss handler states. */
`default_nettype none

package dcache_pkg;

  localparam int index_w = 6;  // 64 direct-mapped lines.
  localparam int row_w = 3;  // low index bits pick the dirty row.
  localparam int col_w = index_w - row_w;  // high index bits pick the column.
  localparam int dirty_rows = 2 ** row_w;
  localparam int dirty_cols = 2 ** col_w;

  typedef logic [index_w-1:0] line_idx_t;

  // miss handler states.
  typedef enum logic [2:0] {
    st_init,    // clearing dirty rows after reset.
    st_idle,
    st_lookup,  // registered lookup results are valid.
    st_wb,
    st_refill,
    st_wait,    // waiting for refill_done.
    st_insert
  } miss_state_t;

  function automatic logic [row_w-1:0] idx_row(input line_idx_t idx);
    return idx[row_w-1:0];
  endfunction

  function automatic logic [col_w-1:0] idx_col(input line_idx_t idx);
    return idx[index_w-1:row_w];
  endfunction

  // one-hot bit enable for the column of a line.
  function automatic logic [dirty_cols-1:0] col_onehot(input line_idx_t idx);
    logic [dirty_cols-1:0] sel;
    sel = '0;
    sel[idx_col(idx)] = 1'b1;
    return sel;
  endfunction

endpackage

`default_nettype wire

// ==== hdl/dirty_bit_ram.sv ====
/* dirty bit RAM: 8 rows of 8 bits, two bit-enabled write ports
   and one read port with a registered row address. */
`default_nettype none

module dirty_bit_ram (
  input  wire                                clk,
  input  wire                                rst,
  input  wire  [dcache_pkg::row_w-1:0]       read_row,
  input  wire                                read_en,
  output logic [dcache_pkg::dirty_cols-1:0]  read_data,
  input  wire  [dcache_pkg::row_w-1:0]       wr0_row,
  input  wire                                wr0_en,
  input  wire  [dcache_pkg::dirty_cols-1:0]  wr0_bit_en,
  input  wire  [dcache_pkg::dirty_cols-1:0]  wr0_data,
  input  wire  [dcache_pkg::row_w-1:0]       wr1_row,
  input  wire                                wr1_en,
  input  wire  [dcache_pkg::dirty_cols-1:0]  wr1_bit_en,
  input  wire  [dcache_pkg::dirty_cols-1:0]  wr1_data
);
  import dcache_pkg::*;

  logic [dirty_cols-1:0] mem [dirty_rows];
  logic [row_w-1:0]      read_row_q;

  // both ports in one block so that port 1 lands last on a shared bit.
  always_ff @(posedge clk) begin
    for (int i = 0; i < dirty_cols; i++) begin
      if (wr0_en && wr0_bit_en[i]) begin
        mem[wr0_row][i] <= wr0_data[i];
      end
      if (wr1_en && wr1_bit_en[i]) begin
        mem[wr1_row][i] <= wr1_data[i];  // overrides port 0.
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      read_row_q <= '0;
    end else if (read_en) begin
      read_row_q <= read_row;
    end
  end

  // array is read live, so writes after the address load show up.
  assign read_data = mem[read_row_q];

endmodule

`default_nettype wire

// ==== hdl/dirty_tracker.sv ====
/* dirty tracker: maps line indices onto the dirty RAM, builds bit enables
   for updates, row clears and commits, and selects the read column. */
`default_nettype none

module dirty_tracker (
  input  wire                         clk,
  input  wire                         rst,
  input  wire dcache_pkg::line_idx_t  rd_idx,
  input  wire                         rd_en,
  output logic                        rd_dirty,
  input  wire dcache_pkg::line_idx_t  upd_idx,
  input  wire                         upd_en,
  input  wire                         upd_value,
  input  wire [dcache_pkg::row_w-1:0] clear_row,
  input  wire                         clear_en,
  input  wire dcache_pkg::line_idx_t  commit_idx,
  input  wire                         commit_en
);
  import dcache_pkg::*;

  logic [row_w-1:0]      wr0_row;
  logic                  wr0_en;
  logic [dirty_cols-1:0] wr0_bit_en;
  logic [dirty_cols-1:0] wr0_data;
  logic [row_w-1:0]      wr1_row;
  logic [dirty_cols-1:0] wr1_bit_en;
  logic [dirty_cols-1:0] read_data;
  logic [col_w-1:0]      rd_col_q;

  // port 0 is shared by the init sweep and single-bit updates.
  always_comb begin
    if (clear_en) begin
      wr0_row    = clear_row;
      wr0_bit_en = '1;  // whole row.
      wr0_data   = '0;
    end else begin
      wr0_row    = idx_row(upd_idx);
      wr0_bit_en = col_onehot(upd_idx);
      wr0_data   = {dirty_cols{upd_value}};
    end
  end

  assign wr0_en = clear_en | upd_en;

  // commits only ever set a bit.
  assign wr1_row    = idx_row(commit_idx);
  assign wr1_bit_en = col_onehot(commit_idx);

  dirty_bit_ram u_ram (
    .clk        (clk),
    .rst        (rst),
    .read_row   (idx_row(rd_idx)),
    .read_en    (rd_en),
    .read_data  (read_data),
    .wr0_row    (wr0_row),
    .wr0_en     (wr0_en),
    .wr0_bit_en (wr0_bit_en),
    .wr0_data   (wr0_data),
    .wr1_row    (wr1_row),
    .wr1_en     (commit_en),
    .wr1_bit_en (wr1_bit_en),
    .wr1_data   ('1)
  );

  // column register tracks the RAM's row register.
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_col_q <= '0;
    end else if (rd_en) begin
      rd_col_q <= idx_col(rd_idx);
    end
  end

  assign rd_dirty = read_data[rd_col_q];

endmodule

`default_nettype wire

// ==== hdl/tag_array.sv ====
/* tag array: valid bits and tags for 64 lines, registered lookup
   giving hit and the victim line's tag. */
`default_nettype none

module tag_array #(
  parameter int tag_w = 10
) (
  input  wire                                   clk,
  input  wire                                   rst,
  input  wire                                   lookup_en,
  input  wire [tag_w+dcache_pkg::index_w-1:0]   lookup_addr,
  output logic                                  hit,
  output logic                                  victim_valid,
  output logic [tag_w-1:0]                      victim_tag,
  input  wire                                   ins_en,
  input  wire dcache_pkg::line_idx_t            ins_idx,
  input  wire [tag_w-1:0]                       ins_tag
);
  import dcache_pkg::*;

  localparam int lines = 2 ** index_w;

  logic [tag_w-1:0] tags [lines];
  logic [lines-1:0] valid;
  line_idx_t        idx_q;
  logic [tag_w-1:0] tag_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= '0;
    end else if (ins_en) begin
      valid[ins_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (ins_en) begin
      tags[ins_idx] <= ins_tag;
    end
  end

  // lookup address register.
  always_ff @(posedge clk) begin
    if (rst) begin
      idx_q <= '0;
    end else if (lookup_en) begin
      idx_q <= lookup_addr[index_w-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (lookup_en) begin
      tag_q <= lookup_addr[tag_w+index_w-1:index_w];
    end
  end

  // compare against the stored line at the registered index.
  assign victim_valid = valid[idx_q];
  assign victim_tag   = tags[idx_q];
  assign hit          = victim_valid && (victim_tag == tag_q);

endmodule

`default_nettype wire

// ==== hdl/miss_handler.sv ====
/* miss handler FSM: init sweep of the dirty RAM, then one access at a time
   through lookup, write-back, refill, refill wait and insert. */
`default_nettype none

module miss_handler #(
  parameter int tag_w = 10
) (
  input  wire                                  clk,
  input  wire                                  rst,
  input  wire                                  acc_valid,
  input  wire                                  acc_store,
  input  wire [tag_w+dcache_pkg::index_w-1:0]  acc_addr,
  input  wire                                  hit,
  input  wire                                  victim_valid,
  input  wire [tag_w-1:0]                      victim_tag,
  input  wire                                  line_dirty,
  input  wire                                  refill_done,
  output logic                                 ready,
  output logic                                 resp_valid,
  output logic                                 resp_hit,
  output logic                                 resp_dirty,
  output logic                                 wb_valid,
  output logic [tag_w+dcache_pkg::index_w-1:0] wb_addr,
  output logic                                 refill_valid,
  output logic [tag_w+dcache_pkg::index_w-1:0] refill_addr,
  output logic                                 upd_en,
  output dcache_pkg::line_idx_t                upd_idx,
  output logic                                 upd_value,
  output logic                                 ins_en,
  output dcache_pkg::line_idx_t                ins_idx,
  output logic [tag_w-1:0]                     ins_tag,
  output logic                                 clear_en,
  output logic [dcache_pkg::row_w-1:0]         clear_row
);
  import dcache_pkg::*;

  miss_state_t      state;
  miss_state_t      state_nxt;
  logic [row_w-1:0] init_row;
  logic             store_q;
  logic [tag_w-1:0] tag_q;
  line_idx_t        idx_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= st_init;
      init_row <= '0;
    end else begin
      state <= state_nxt;
      if (state == st_init) begin
        init_row <= init_row + 1'b1;  // one row per cycle.
      end
    end
  end

  // access is latched when it is accepted.
  always_ff @(posedge clk) begin
    if (state == st_idle && acc_valid) begin
      {tag_q, idx_q} <= acc_addr;
      store_q        <= acc_store;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      st_init: begin
        if (init_row == row_w'(dirty_rows - 1)) begin
          state_nxt = st_idle;
        end
      end
      st_idle: begin
        if (acc_valid) begin
          state_nxt = st_lookup;
        end
      end
      st_lookup: begin
        if (hit) begin
          state_nxt = st_idle;
        end else if (victim_valid && line_dirty) begin
          state_nxt = st_wb;  // dirty victim goes out first.
        end else begin
          state_nxt = st_refill;
        end
      end
      st_wb:     state_nxt = st_refill;
      st_refill: state_nxt = st_wait;
      st_wait: begin
        if (refill_done) begin
          state_nxt = st_insert;
        end
      end
      st_insert: state_nxt = st_idle;
      default:   state_nxt = st_idle;
    endcase
  end

  assign ready      = (state == st_idle);
  assign resp_valid = (state == st_lookup);
  assign resp_hit   = resp_valid & hit;
  assign resp_dirty = resp_valid & line_dirty;  // value before this access.

  // the lookup index stays put while busy, so victim_tag is still current.
  assign wb_valid     = (state == st_wb);
  assign wb_addr      = {victim_tag, idx_q};
  assign refill_valid = (state == st_refill);
  assign refill_addr  = {tag_q, idx_q};

  // dirty port 0 for store hits and inserts.
  assign upd_en    = (resp_hit && store_q) || (state == st_insert);
  assign upd_idx   = idx_q;
  assign upd_value = store_q;

  assign ins_en  = (state == st_insert);
  assign ins_idx = idx_q;
  assign ins_tag = tag_q;

  assign clear_en  = (state == st_init);
  assign clear_row = init_row;

endmodule

`default_nettype wire

// ==== hdl/dcache_meta_top.sv ====
/* cache metadata top level: tag array, dirty tracker and miss handler,
   with the access port, store commit port and refill interface. */
`default_nettype none

module dcache_meta_top #(
  parameter int tag_w = 10
) (
  input  wire                                  clk,
  input  wire                                  rst,
  input  wire                                  acc_valid,
  input  wire                                  acc_store,
  input  wire [tag_w+dcache_pkg::index_w-1:0]  acc_addr,
  output wire                                  ready,
  output wire                                  resp_valid,
  output wire                                  resp_hit,
  output wire                                  resp_dirty,
  input  wire                                  st_valid,
  input  wire dcache_pkg::line_idx_t           st_addr,
  output wire                                  wb_valid,
  output wire [tag_w+dcache_pkg::index_w-1:0]  wb_addr,
  output wire                                  refill_valid,
  output wire [tag_w+dcache_pkg::index_w-1:0]  refill_addr,
  input  wire                                  refill_done
);
  import dcache_pkg::*;

  logic             lookup_en;
  logic             hit;
  logic             victim_valid;
  logic [tag_w-1:0] victim_tag;
  logic             line_dirty;
  logic             upd_en;
  line_idx_t        upd_idx;
  logic             upd_value;
  logic             ins_en;
  line_idx_t        ins_idx;
  logic [tag_w-1:0] ins_tag;
  logic             clear_en;
  logic [row_w-1:0] clear_row;

  // accesses outside ready are dropped.
  assign lookup_en = acc_valid & ready;

  tag_array #(
    .tag_w (tag_w)
  ) u_tags (
    .clk          (clk),
    .rst          (rst),
    .lookup_en    (lookup_en),
    .lookup_addr  (acc_addr),
    .hit          (hit),
    .victim_valid (victim_valid),
    .victim_tag   (victim_tag),
    .ins_en       (ins_en),
    .ins_idx      (ins_idx),
    .ins_tag      (ins_tag)
  );

  dirty_tracker u_dirty (
    .clk        (clk),
    .rst        (rst),
    .rd_idx     (acc_addr[index_w-1:0]),
    .rd_en      (lookup_en),
    .rd_dirty   (line_dirty),
    .upd_idx    (upd_idx),
    .upd_en     (upd_en),
    .upd_value  (upd_value),
    .clear_row  (clear_row),
    .clear_en   (clear_en),
    .commit_idx (st_addr),
    .commit_en  (st_valid)
  );

  miss_handler #(
    .tag_w (tag_w)
  ) u_miss (
    .clk          (clk),
    .rst          (rst),
    .acc_valid    (lookup_en),
    .acc_store    (acc_store),
    .acc_addr     (acc_addr),
    .hit          (hit),
    .victim_valid (victim_valid),
    .victim_tag   (victim_tag),
    .line_dirty   (line_dirty),
    .refill_done  (refill_done),
    .ready        (ready),
    .resp_valid   (resp_valid),
    .resp_hit     (resp_hit),
    .resp_dirty   (resp_dirty),
    .wb_valid     (wb_valid),
    .wb_addr      (wb_addr),
    .refill_valid (refill_valid),
    .refill_addr  (refill_addr),
    .upd_en       (upd_en),
    .upd_idx      (upd_idx),
    .upd_value    (upd_value),
    .ins_en       (ins_en),
    .ins_idx      (ins_idx),
    .ins_tag      (ins_tag),
    .clear_en     (clear_en),
    .clear_row    (clear_row)
  );

endmodule

`default_nettype wire

// ==== tests/tb_tasks.svh ====
/* testbench helpers: compare tasks, timed waits, access and commit drivers,
   and the directed tests. */
`ifndef tb_tasks_svh
`define tb_tasks_svh

task automatic abort_run();
  $display("STATUS: FAIL");
  $fatal(1, "stopped at first error");
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
    abort_run();
  end
endtask

task automatic check_addr(input string name, input logic [addr_w-1:0] got,
                          input logic [addr_w-1:0] exp);
  if (got !== exp) begin
    $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    abort_run();
  end
endtask

task automatic check_idx(input string name, input line_idx_t got, input line_idx_t exp);
  if (got !== exp) begin
    $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
    abort_run();
  end
endtask

function automatic logic event_seen(input int which);
  case (which)
    ev_ready:        return ready;
    ev_resp:         return resp_valid;
    ev_wb_or_refill: return wb_valid || refill_valid;
    default:         return refill_valid;
  endcase
endfunction

// outputs are sampled on the falling edge.
task automatic wait_until(input int which, input string what);
  int n;
  n = 0;
  @(negedge clk);
  while (!event_seen(which)) begin
    if (n == wait_limit) begin
      $display("timeout at %0t: no %s within %0d cycles", $time, what, wait_limit);
      abort_run();
    end else begin
      n++;
      @(negedge clk);
    end
  end
endtask

task automatic start_access(input logic store, input logic [addr_w-1:0] addr,
                            output logic missed);
  line_idx_t        idx;
  logic [tag_w-1:0] tag;
  logic             exp_hit;
  logic             exp_wb;
  idx     = addr[index_w-1:0];
  tag     = addr[addr_w-1:index_w];
  exp_hit = m_valid[idx] && (m_tag[idx] == tag);
  exp_wb  = !exp_hit && m_valid[idx] && m_dirty[idx];  // dirty resident victim.
  missed  = !exp_hit;
  wait_until(ev_ready, "ready");
  @(posedge clk);
  acc_valid <= 1'b1;
  acc_store <= store;
  acc_addr  <= addr;
  @(posedge clk);
  acc_valid <= 1'b0;
  wait_until(ev_resp, "resp_valid");
  check_bit("resp_hit", resp_hit, exp_hit);
  check_bit("resp_dirty", resp_dirty, m_dirty[idx]);  // bit before the access.
  if (exp_hit) begin
    if (store) begin
      m_dirty[idx] = 1'b1;
    end
  end else begin
    pend_idx   = idx;
    pend_tag   = tag;
    pend_store = store;
    wait_until(ev_wb_or_refill, "write-back or refill");
    check_bit("wb_valid", wb_valid, exp_wb);
    if (wb_valid) begin
      check_idx("wb_addr index", wb_addr[index_w-1:0], idx);
      check_addr("wb_addr", wb_addr, {m_tag[idx], idx});
      wait_until(ev_refill, "refill_valid");
    end
    check_addr("refill_addr", refill_addr, addr);
  end
endtask

task automatic finish_refill();
  int lat;
  lat = rand_bits(2);  // refill latency varies.
  repeat (lat) @(posedge clk);
  @(posedge clk);
  refill_done <= 1'b1;
  @(posedge clk);
  refill_done <= 1'b0;
  m_valid[pend_idx] = 1'b1;
  m_tag[pend_idx]   = pend_tag;
  m_dirty[pend_idx] = pend_store;
endtask

task automatic access(input logic store, input logic [addr_w-1:0] addr);
  logic missed;
  start_access(store, addr, missed);
  if (missed) begin
    finish_refill();
  end
endtask

task automatic commit(input int idx);
  @(posedge clk);
  st_valid <= 1'b1;
  st_addr  <= line_idx_t'(idx);
  @(posedge clk);
  st_valid <= 1'b0;
  m_dirty[idx] = 1'b1;
endtask

task automatic test_after_reset();
  @(negedge clk);
  check_bit("ready", ready, 1'b0);  // dirty rows are still being cleared.
  check_bit("resp_valid", resp_valid, 1'b0);
  check_bit("wb_valid", wb_valid, 1'b0);
  check_bit("refill_valid", refill_valid, 1'b0);
  wait_until(ev_ready, "ready after reset");
  access(1'b0, mk_addr(17, 5));  // cold miss without a write-back.
endtask

task automatic test_load_hit();
  access(1'b0, mk_addr(17, 5));
  access(1'b0, mk_addr(17, 5));  // still clean.
endtask

task automatic test_store_evict();
  access(1'b1, mk_addr(17, 5));
  access(1'b0, mk_addr(17, 5));
  access(1'b0, mk_addr(34, 5));  // evicts dirty tag 17.
endtask

task automatic test_commit();
  logic missed;
  access(1'b0, mk_addr(51, 12));
  commit(12);
  access(1'b0, mk_addr(51, 12));
  access(1'b0, mk_addr(51, 20));
  start_access(1'b0, mk_addr(68, 41), missed);
  commit(20);  // lands while line 41 waits for its refill.
  if (missed) begin
    finish_refill();
  end
  access(1'b0, mk_addr(51, 20));
endtask

task automatic test_store_miss();
  access(1'b1, mk_addr(85, 33));
  access(1'b0, mk_addr(102, 33));
  access(1'b0, mk_addr(119, 33));  // clean victim.
endtask

task automatic test_random();
  int   tag;
  int   idx;
  logic store;
  for (int i = 0; i < 200; i++) begin
    tag = rand_bits(2);
    idx = rand_bits(4);  // few lines and tags, so conflicts are frequent.
    if (rand_bits(2) == 0 && m_valid[idx]) begin
      commit(idx);
    end else begin
      store = (rand_bits(1) == 1);
      access(store, mk_addr(tag, idx));
    end
  end
endtask

`endif

// ==== tests/tb_dcache_meta.sv ====
/* testbench for the cache metadata top level: clock, reset, LFSR stimulus,
   reference model of valid, tag and dirty state, and the directed test sequence. */
`default_nettype none

module tb_dcache_meta;
  import dcache_pkg::*;

  localparam int tag_w      = 10;
  localparam int addr_w     = tag_w + index_w;
  localparam int lines      = 2 ** index_w;
  localparam int wait_limit = 64;  // cycles per wait before giving up.

  // wait conditions for wait_until.
  localparam int ev_ready        = 0;
  localparam int ev_resp         = 1;
  localparam int ev_wb_or_refill = 2;
  localparam int ev_refill       = 3;

  logic              clk;
  logic              rst;
  logic              acc_valid;
  logic              acc_store;
  logic [addr_w-1:0] acc_addr;
  logic              ready;
  logic              resp_valid;
  logic              resp_hit;
  logic              resp_dirty;
  logic              st_valid;
  line_idx_t         st_addr;
  logic              wb_valid;
  logic [addr_w-1:0] wb_addr;
  logic              refill_valid;
  logic [addr_w-1:0] refill_addr;
  logic              refill_done;

  // reference model with one entry per line.
  logic             m_valid [lines];
  logic [tag_w-1:0] m_tag   [lines];
  logic             m_dirty [lines];

  // miss waiting for its refill.
  line_idx_t        pend_idx;
  logic [tag_w-1:0] pend_tag;
  logic             pend_store;

  logic [31:0] lfsr_state;

  dcache_meta_top #(
    .tag_w (tag_w)
  ) dut (
    .clk          (clk),
    .rst          (rst),
    .acc_valid    (acc_valid),
    .acc_store    (acc_store),
    .acc_addr     (acc_addr),
    .ready        (ready),
    .resp_valid   (resp_valid),
    .resp_hit     (resp_hit),
    .resp_dirty   (resp_dirty),
    .st_valid     (st_valid),
    .st_addr      (st_addr),
    .wb_valid     (wb_valid),
    .wb_addr      (wb_addr),
    .refill_valid (refill_valid),
    .refill_addr  (refill_addr),
    .refill_done  (refill_done)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // galois LFSR over x^32 + x^22 + x^2 + x + 1 that steps once per bit taken.
  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | int'(lfsr_state[0]);
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
    end
    return v;
  endfunction

  function automatic logic [addr_w-1:0] mk_addr(input int tag, input int idx);
    return {tag_w'(tag), line_idx_t'(idx)};
  endfunction

  `include "tb_tasks.svh"

  initial begin
    rst         <= 1'b1;
    acc_valid   <= 1'b0;
    acc_store   <= 1'b0;
    acc_addr    <= '0;
    st_valid    <= 1'b0;
    st_addr     <= '0;
    refill_done <= 1'b0;
    lfsr_state = 32'd98838;
    for (int i = 0; i < lines; i++) begin
      m_valid[i] = 1'b0;
      m_tag[i]   = '0;
      m_dirty[i] = 1'b0;  // init sweep clears every row.
    end
    repeat (16) @(posedge clk);
    rst <= 1'b0;

    test_after_reset();
    test_load_hit();
    test_store_evict();
    test_commit();
    test_store_miss();
    test_random();

    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+tests
hdl/dcache_pkg.sv
hdl/dirty_bit_ram.sv
hdl/dirty_tracker.sv
hdl/tag_array.sv
hdl/miss_handler.sv
hdl/dcache_meta_top.sv
tests/tb_dcache_meta.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the cache metadata testbench with Verilator.
# the exit status of the simulation is the result of the run.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_dcache_meta -f src.f -o tb_dcache_meta

./obj_dir/tb_dcache_meta
